// ==== rtl/ooo_issue_pkg.sv ====
package ooo_issue_pkg;

    // architectural register file shape
    localparam int REG_ADDR_LEN = 4;  // bits needed to name one of the registers
    localparam int REG_NUM      = 16; // r0 is hardwired to zero in the execute unit
    localparam int DATA_WIDTH   = 16; // integer datapath width

    // issue queue shape
    localparam int NUM_ENTRIES  = 4;  // reservation entries in the queue
    localparam int ENTRY_WIDTH  = 2;  // index and age width, NUM_ENTRIES is 2**ENTRY_WIDTH

    // the multiply occupies execute for this many cycles before write-back
    localparam int MUL_LATENCY  = 3;

    // operation codes carried by every renamed instruction
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // dst = inp1 + inp2
        ALU_SUB = 3'd1, // dst = inp1 - inp2
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_MUL = 3'd5  // low half of the product, multi-cycle
    } al_func_t;

    // a renamed instruction as it leaves the renamer, 15 bits
    typedef struct packed {
        al_func_t                insn; // operation
        logic [REG_ADDR_LEN-1:0] inp1; // first source register
        logic [REG_ADDR_LEN-1:0] inp2; // second source register
        logic [REG_ADDR_LEN-1:0] dst;  // destination, never equal to a source
    } dispatch_insn_t;

    // one reservation entry inside the issue queue
    typedef struct packed {
        dispatch_insn_t         uop;    // the waiting instruction
        logic                   ready1; // inp1 value is available in the register file
        logic                   ready2; // inp2 value is available in the register file
        logic [ENTRY_WIDTH-1:0] bday;   // age among valid entries, 0 is the oldest
        logic                   valid;  // entry holds an instruction
    } issue_entry_t;

    // write-back record, sent with the wakeup pulse, 20 bits
    typedef struct packed {
        logic [REG_ADDR_LEN-1:0] dst;  // register being written
        logic [DATA_WIDTH-1:0]   data; // value written
    } wb_t;

endpackage

// ==== rtl/dispatch_unit.sv ====
`timescale 1ns/100ps

module dispatch_unit import ooo_issue_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,  // one-cycle strobe from the renamer
    input  dispatch_insn_t in_insn,   // renamed instruction, valid with in_valid
    output logic           in_ready,  // skid register can take an instruction this cycle
    input  logic           is_full,   // issue queue has no free entry
    output logic           load,      // write the pending instruction into the queue
    output dispatch_insn_t load_insn  // the pending instruction
);

    logic           pending;      // skid register holds an instruction
    dispatch_insn_t pending_insn; // skid register payload
    logic           accept;       // renamer handoff happens at this edge

    // the pending instruction moves on as soon as the queue has room
    assign load      = pending && !is_full;
    assign load_insn = pending_insn;

    // the skid register is free if empty, or if it drains into the queue this cycle
    assign in_ready = !pending || load;
    assign accept   = in_valid && in_ready;

    // pending flag, a refill in the same cycle as a drain keeps it set
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (load) begin
            pending <= 1'b0; // drained and nothing new arrived
        end
    end

    // payload is only captured on a handoff
    always_ff @(posedge clk) begin
        if (accept) begin
            pending_insn <= in_insn;
        end
    end

    // the queue marks dst not ready on load, so a self-dependent instruction
    // would wait forever on its own write-back
    assert property (@(posedge clk) disable iff (reset)
        accept |-> (in_insn.dst != in_insn.inp1) && (in_insn.dst != in_insn.inp2))
        else $error("dispatch: instruction names its destination as a source");

endmodule

// ==== rtl/issue_queue.sv ====
`timescale 1ns/100ps

module issue_queue import ooo_issue_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,        // dispatch writes load_insn this cycle
    input  dispatch_insn_t load_insn,   // instruction to enter the queue
    input  logic           issue,       // execute can take an instruction next cycle
    input  logic           wakeup,      // write-back pulse from execute
    input  wb_t            wb,          // register written with the wakeup
    output logic           is_full,     // every entry is occupied
    output logic           issue_ready, // issued holds a fresh instruction this cycle
    output dispatch_insn_t issued       // oldest ready instruction picked at the last edge
);

    issue_entry_t       entries [NUM_ENTRIES]; // reservation entries
    logic [REG_NUM-1:0] ready_table;           // one bit per register, set when its value is final

    logic [ENTRY_WIDTH:0]   num_used;    // 0 to NUM_ENTRIES, one bit wider than an index
    logic [NUM_ENTRIES-1:0] ready_flags; // valid entries whose sources are both ready
    logic                   exist_ready; // at least one entry can issue
    logic                   do_issue;    // an entry leaves the queue at this edge
    logic [ENTRY_WIDTH-1:0] min_age;     // age of the selected entry
    logic [ENTRY_WIDTH-1:0] min_idx;     // slot of the selected entry
    logic [ENTRY_WIDTH-1:0] free_idx;    // lowest empty slot, only meaningful when not full
    logic [ENTRY_WIDTH:0]   load_age;    // age of an entry loaded at this edge
    logic                   src1_ready;  // ready bits for the entry being loaded
    logic                   src2_ready;
    logic                   age_clash;   // two valid entries claim the same age

    // occupancy count
    always_comb begin
        num_used = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entries[i].valid) begin
                num_used = num_used + 1'b1;
            end
        end
    end

    assign is_full = (num_used == NUM_ENTRIES);

    // an entry is a candidate once both of its sources have been woken
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ready_flags[i] = entries[i].valid && entries[i].ready1 && entries[i].ready2;
        end
    end

    assign exist_ready = |ready_flags;
    assign do_issue    = issue && exist_ready;

    // oldest-ready select, ages are unique so two candidates never tie
    always_comb begin
        min_age = '1;
        min_idx = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ready_flags[i] && (entries[i].bday <= min_age)) begin
                min_age = entries[i].bday;
                min_idx = ENTRY_WIDTH'(i);
            end
        end
    end

    // first free slot, scanned from the top so the lowest index wins
    always_comb begin
        free_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx = ENTRY_WIDTH'(i);
            end
        end
    end

    // the new entry is youngest, one slot younger less if an entry departs alongside it
    assign load_age = num_used - {{ENTRY_WIDTH{1'b0}}, do_issue};

    // source ready bits, with a same-cycle write-back forwarded past the table
    assign src1_ready = ready_table[load_insn.inp1] || (wakeup && (wb.dst == load_insn.inp1));
    assign src2_ready = ready_table[load_insn.inp2] || (wakeup && (wb.dst == load_insn.inp2));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].bday  <= '0;
            end
            ready_table <= '1; // every register starts with a final value
            issue_ready <= 1'b0;
        end else begin
            issue_ready <= do_issue;

            // write-back wakes the table and any waiting consumer
            if (wakeup) begin
                ready_table[wb.dst] <= 1'b1;
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (entries[i].valid && (entries[i].uop.inp1 == wb.dst)) begin
                        entries[i].ready1 <= 1'b1;
                    end
                    if (entries[i].valid && (entries[i].uop.inp2 == wb.dst)) begin
                        entries[i].ready2 <= 1'b1;
                    end
                end
            end

            // the selected entry leaves and everything younger moves one step older
            if (do_issue) begin
                entries[min_idx].valid <= 1'b0;
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (entries[i].valid && (entries[i].bday > min_age)) begin
                        entries[i].bday <= entries[i].bday - 1'b1;
                    end
                end
            end

            // load targets an empty slot, so it never collides with the issue above
            if (load) begin
                entries[free_idx].uop    <= load_insn;
                entries[free_idx].ready1 <= src1_ready;
                entries[free_idx].ready2 <= src2_ready;
                entries[free_idx].bday   <= load_age[ENTRY_WIDTH-1:0];
                entries[free_idx].valid  <= 1'b1;
                // later in the block than the wakeup, so the new producer wins
                if (load_insn.dst != '0) begin
                    ready_table[load_insn.dst] <= 1'b0; // r0 is always ready
                end
            end
        end
    end

    // the instruction handed to execute
    always_ff @(posedge clk) begin
        if (do_issue) begin
            issued <= entries[min_idx].uop;
        end
    end

    // ages must stay a permutation of the occupied positions
    always_comb begin
        age_clash = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int j = i + 1; j < NUM_ENTRIES; j++) begin
                if (entries[i].valid && entries[j].valid &&
                    (entries[i].bday == entries[j].bday)) begin
                    age_clash = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) load |-> !is_full)
        else $error("issue_queue: load while full");

    assert property (@(posedge clk) disable iff (reset) !age_clash)
        else $error("issue_queue: two valid entries share an age");

    // back-to-back issues need execute to have kept issue high through both cycles
    assert property (@(posedge clk) disable iff (reset)
        (issue_ready && $past(issue_ready)) |-> ($past(issue) && $past(issue, 2)))
        else $error("issue_queue: issue_ready repeated without issue");

endmodule

// ==== rtl/alu_exec.sv ====
`timescale 1ns/100ps

module alu_exec import ooo_issue_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           issue_ready, // queue hands over an instruction this cycle
    input  dispatch_insn_t issued,      // the instruction to execute
    output logic           issue,       // execute can accept an instruction next cycle
    output logic           wakeup,      // write-back pulse
    output wb_t            wb           // destination and result with the pulse
);

    logic [DATA_WIDTH-1:0]   regs [REG_NUM]; // architectural register file
    logic [DATA_WIDTH-1:0]   src1;           // operand values read at issue
    logic [DATA_WIDTH-1:0]   src2;
    logic [DATA_WIDTH-1:0]   result;         // combinational result of the issued op
    logic                    is_mul;         // issued instruction is a multiply
    logic [1:0]              mul_count;      // cycles left before the multiply writes back
    logic                    mul_busy;
    logic                    mul_done;       // last countdown cycle, write-back at this edge
    logic [DATA_WIDTH-1:0]   mul_prod;       // product held through the countdown
    logic [REG_ADDR_LEN-1:0] mul_dst;

    // operands come straight from the register file, dependents only issue after the write
    assign src1 = regs[issued.inp1];
    assign src2 = regs[issued.inp2];

    always_comb begin
        case (issued.insn)
            ALU_ADD: result = src1 + src2;
            ALU_SUB: result = src1 - src2;
            ALU_AND: result = src1 & src2;
            ALU_OR:  result = src1 | src2;
            ALU_XOR: result = src1 ^ src2;
            ALU_MUL: result = src1 * src2; // low half of the product
            default: result = '0;
        endcase
    end

    assign is_mul   = issue_ready && (issued.insn == ALU_MUL);
    assign mul_busy = (mul_count != '0);
    assign mul_done = (mul_count == 2'd1);

    // no new work while a multiply is entering or in flight, the wakeup cycle is free again
    assign issue = !is_mul && !mul_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_count <= '0;
            wakeup    <= 1'b0;
        end else begin
            wakeup <= (issue_ready && !is_mul) || mul_done;
            if (is_mul) begin
                mul_count <= 2'(MUL_LATENCY - 1);
            end else if (mul_busy) begin
                mul_count <= mul_count - 1'b1;
            end
        end
    end

    // write-back payload, a logic op and a multiply never finish in the same cycle
    always_ff @(posedge clk) begin
        if (is_mul) begin
            mul_prod <= result;
            mul_dst  <= issued.dst;
        end
        if (issue_ready && !is_mul) begin
            wb <= '{dst: issued.dst, data: result};
        end else if (mul_done) begin
            wb <= '{dst: mul_dst, data: mul_prod};
        end
    end

    // register file, each register starts out holding its own index
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= DATA_WIDTH'(i);
            end
        end else if (wakeup && (wb.dst != '0)) begin
            regs[wb.dst] <= wb.data; // r0 stays zero
        end
    end

    assert property (@(posedge clk) disable iff (reset) issue_ready |-> !mul_busy)
        else $error("alu_exec: instruction issued while multiply busy");

endmodule

// ==== rtl/ooo_issue_top.sv ====
`timescale 1ns/100ps

module ooo_issue_top import ooo_issue_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid, // renamed instruction strobe
    input  dispatch_insn_t in_insn,
    output logic           in_ready, // dispatch can take in_insn
    output logic           wakeup,   // write-back pulse
    output wb_t            wb        // write-back record
);

    logic           is_full;     // queue to dispatch back-pressure
    logic           load;        // dispatch to queue
    dispatch_insn_t load_insn;
    logic           issue;       // execute asks the queue for work
    logic           issue_ready; // queue hands an instruction to execute
    dispatch_insn_t issued;

    dispatch_unit u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_insn   (in_insn),
        .in_ready  (in_ready),
        .is_full   (is_full),
        .load      (load),
        .load_insn (load_insn)
    );

    issue_queue u_queue (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .load_insn   (load_insn),
        .issue       (issue),
        .wakeup      (wakeup),   // write-back wakes waiting consumers
        .wb          (wb),
        .is_full     (is_full),
        .issue_ready (issue_ready),
        .issued      (issued)
    );

    alu_exec u_exec (
        .clk         (clk),
        .reset       (reset),
        .issue_ready (issue_ready),
        .issued      (issued),
        .issue       (issue),
        .wakeup      (wakeup),
        .wb          (wb)
    );

endmodule

// ==== verification/ooo_issue_tb.sv ====
`timescale 1ns/100ps

module ooo_issue_tb import ooo_issue_pkg::*; ();

    localparam int TOTAL_INSNS = 61;               // 6 + 5 + 8 + 2 + 40 over all directed tests
    localparam int MAX_CYCLES  = 40 * TOTAL_INSNS; // generous budget per instruction sent

    logic           clk;
    logic           reset;
    logic           in_valid;
    dispatch_insn_t in_insn;
    logic           in_ready;
    logic           wakeup;
    wb_t            wb;

    logic [DATA_WIDTH-1:0]   ref_regs [REG_NUM]; // architectural state, updated in program order
    logic [DATA_WIDTH-1:0]   exp_data [REG_NUM]; // expected write-back value per in-flight dst
    logic [REG_ADDR_LEN-1:0] src1_of [REG_NUM];  // sources of the in-flight writer of each dst
    logic [REG_ADDR_LEN-1:0] src2_of [REG_NUM];
    int                      readers [REG_NUM];  // in-flight instructions that read a register
    logic [REG_NUM-1:0]      in_flight;          // dst still waiting for its write-back
    logic [REG_NUM-1:0]      woken;              // dsts seen on wb since the mask was cleared
    logic [REG_ADDR_LEN-1:0] wb_order [$];       // dsts in write-back order
    int                      outstanding;        // instructions sent and not yet written back
    logic                    saw_stall;          // an offer was held back by in_ready
    logic [31:0]             rng;
    int                      cycles;

    ooo_issue_top UUT (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_insn  (in_insn),
        .in_ready (in_ready),
        .wakeup   (wakeup),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // the run may never outlast the cycle budget
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: %0d write-backs still missing after %0d cycles",
                         outstanding, MAX_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "run stopped on timeout");
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // what each operation means on 16-bit registers
    function automatic logic [DATA_WIDTH-1:0] op_result(input al_func_t op,
                                                       input logic [DATA_WIDTH-1:0] a,
                                                       input logic [DATA_WIDTH-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_MUL: return a * b; // only the low half is kept
            default: return '0;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // wakeup and wb are registered, so they are steady at the falling edge
    always @(negedge clk) begin
        if (!reset && in_valid && !in_ready) begin
            saw_stall = 1'b1;
        end
        if (!reset && wakeup) begin
            check_equal(32'(in_flight[wb.dst]), 32'd1,
                        $sformatf("wakeup for r%0d with nothing in flight", wb.dst));
            check_equal(32'(wb.data), 32'(exp_data[wb.dst]),
                        $sformatf("write-back data of r%0d", wb.dst));
            in_flight[wb.dst] = 1'b0;
            readers[src1_of[wb.dst]]--; // its sources may now be overwritten
            readers[src2_of[wb.dst]]--;
            woken[wb.dst] = 1'b1;
            wb_order.push_back(wb.dst);
            outstanding--;
        end
    end

    // the reference result is fixed in program order, then the strobe waits for in_ready
    task automatic send(input dispatch_insn_t insn);
        logic [DATA_WIDTH-1:0] value;
        value = op_result(insn.insn, ref_regs[insn.inp1], ref_regs[insn.inp2]);
        if (insn.dst != '0) begin
            ref_regs[insn.dst] = value; // r0 keeps reading as zero
        end
        exp_data[insn.dst]  = value;
        src1_of[insn.dst]   = insn.inp1;
        src2_of[insn.dst]   = insn.inp2;
        in_flight[insn.dst] = 1'b1;
        readers[insn.inp1]++;
        readers[insn.inp2]++;
        outstanding++;
        in_valid = 1'b1;
        in_insn  = insn;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk); // handoff edge
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_after_reset();
        repeat (5) begin
            check_equal(32'(in_ready), 32'd1, "in_ready low after reset");
            check_equal(32'(wakeup), 32'd0, "wakeup seen after reset");
            @(posedge clk);
            #1;
        end
    endtask

    // all sources already final, so oldest-first issue keeps program order
    task automatic independent_logic_in_order();
        wb_order.delete();
        for (int i = 0; i < 6; i++) begin
            send('{insn: al_func_t'(i % 5), inp1: REG_ADDR_LEN'(i + 1),
                   inp2: REG_ADDR_LEN'(i + 2), dst: REG_ADDR_LEN'(8 + i)});
        end
        wait_drain();
        check_equal(wb_order.size(), 6, "logic write-back count");
        for (int i = 0; i < 6; i++) begin
            check_equal(32'(wb_order[i]), 32'(8 + i), "logic write-back order");
        end
    endtask

    task automatic mul_dependency_chain();
        woken = '0;
        send('{insn: ALU_MUL, inp1: 4'd2, inp2: 4'd3, dst: 4'd1});
        send('{insn: ALU_ADD, inp1: 4'd1, inp2: 4'd2, dst: 4'd4}); // waits for the multiply
        send('{insn: ALU_MUL, inp1: 4'd4, inp2: 4'd1, dst: 4'd5});
        send('{insn: ALU_XOR, inp1: 4'd5, inp2: 4'd4, dst: 4'd6});
        send('{insn: ALU_SUB, inp1: 4'd6, inp2: 4'd1, dst: 4'd7});
        wait_drain();
        check_equal(32'(woken), 32'h0000_00f2, "chain destinations written");
    endtask

    task automatic mul_backpressure();
        saw_stall = 1'b0;
        woken     = '0;
        for (int i = 0; i < 8; i++) begin
            send('{insn: ALU_MUL, inp1: REG_ADDR_LEN'(1 + i % 7),
                   inp2: REG_ADDR_LEN'(1 + (i + 3) % 7), dst: REG_ADDR_LEN'(8 + i)});
        end
        wait_drain();
        check_equal(32'(saw_stall), 32'd1, "in_ready never dropped with a full queue");
        check_equal(32'(woken), 32'h0000_ff00, "multiply destinations written");
    endtask

    task automatic r0_destination();
        woken = '0;
        send('{insn: ALU_ADD, inp1: 4'd3, inp2: 4'd4, dst: 4'd0}); // result is discarded
        send('{insn: ALU_OR, inp1: 4'd0, inp2: 4'd6, dst: 4'd9});  // r0 still reads zero
        wait_drain();
        check_equal(32'(woken[0]), 32'd1, "no wakeup for an r0 destination");
    endtask

    task automatic random_mix();
        logic [REG_ADDR_LEN-1:0] d;
        logic [REG_ADDR_LEN-1:0] a;
        logic [REG_ADDR_LEN-1:0] b;
        logic [REG_NUM-1:0]      sent;
        al_func_t                op;
        sent  = '0;
        woken = '0;
        for (int n = 0; n < 40; n++) begin
            rng = xorshift32(rng);
            d   = rng[REG_ADDR_LEN-1:0];
            // act as the renamer, no dst that is still written or read in flight
            while (in_flight[d] || readers[d] != 0) begin
                @(posedge clk);
                #1;
                rng = xorshift32(rng);
                d   = rng[REG_ADDR_LEN-1:0];
            end
            rng = xorshift32(rng);
            op  = al_func_t'(rng[15:0] % 6);
            a   = rng[19:16];
            b   = rng[23:20];
            if (a == d) begin
                a = d ^ 4'd1; // a source never equals its own dst
            end
            if (b == d) begin
                b = d ^ 4'd1;
            end
            sent[d] = 1'b1;
            send('{insn: op, inp1: a, inp2: b, dst: d});
        end
        wait_drain();
        check_equal(32'(woken), 32'(sent), "random mix destinations written");
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_insn     = '0;
        rng         = 32'h84ec;
        in_flight   = '0;
        woken       = '0;
        outstanding = 0;
        saw_stall   = 1'b0;
        for (int i = 0; i < REG_NUM; i++) begin
            ref_regs[i] = DATA_WIDTH'(i); // registers come out of reset holding their index
            exp_data[i] = '0;
            src1_of[i]  = '0;
            src2_of[i]  = '0;
            readers[i]  = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_after_reset();
        independent_logic_in_order();
        mul_dependency_chain();
        mul_backpressure();
        r0_destination();
        random_mix();
        if (outstanding == 0 && in_flight == '0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("instructions left without a write-back at the end of the run");
            $display("TEST FAILED");
            $fatal(1, "run ended with work in flight");
        end
    end

endmodule

// ==== ooo_issue.f ====
rtl/ooo_issue_pkg.sv
rtl/dispatch_unit.sv
rtl/issue_queue.sv
rtl/alu_exec.sv
rtl/ooo_issue_top.sv
verification/ooo_issue_tb.sv

// ==== Makefile ====
SOURCES := $(shell cat ooo_issue.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vooo_issue_tb: ooo_issue.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module ooo_issue_tb -f ooo_issue.f

# the run passes only if the pass line shows up in the output
run: obj_dir/Vooo_issue_tb
	@out="$$(./obj_dir/Vooo_issue_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
